/* Bender.yml */
package:
  name: rtx

sources:
  - logic/rtx_pkg.sv
  - logic/scene_buffer.sv
  - logic/ray_scheduler.sv
  - logic/object_decode.sv
  - logic/hit_test.sv
  - logic/nearest_hit.sv
  - logic/rtx.sv
  - target: test
    files:
      - bench/rtx_tb.sv

/* bench/rtx_tb.sv */
`timescale 1ns/1ns

module rtx_tb;
  import rtx_pkg::*;

  localparam int NPIX   = FRAME_H * FRAME_V;
  localparam int NWORDS = 256; // command memory, three words per command

  logic                  clk_rtx;
  logic                  sys_rst;
  logic [APB_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  pixel_t                pixel;
  logic                  ray_done;

  logic [31:0]           cmds [NWORDS]; // op, a, b
  logic [COLOR_W-1:0]    frame [NPIX];  // colors in arrival order
  logic [APB_DATA_W-1:0] rd_data;
  logic                  rd_err;
  int npix   = 0; // pixels seen since the last render started
  int errs   = 0;
  int cycles = 0;
  int limit  = 0; // 0 until the command file is scanned

  rtx uut (.*);

  initial begin
    clk_rtx = 1'b0;
    forever #4 clk_rtx = ~clk_rtx; // 8 ns period
  end

  always @(posedge clk_rtx) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // pixel collector, registered outputs are settled at the falling edge
  always @(negedge clk_rtx) begin
    if (ray_done) begin
      assert (pixel.h == COORD_W'(npix % FRAME_H) &&
              pixel.v == COORD_W'(npix / FRAME_H)) else begin
        $display("[FAIL] %0t pixel %0d at h=%0d v=%0d, raster order wants h=%0d v=%0d",
                 $time, npix, pixel.h, pixel.v, npix % FRAME_H, npix / FRAME_H);
        errs++;
      end
      if (npix < NPIX)
        frame[npix] = pixel.color;
      npix++;
    end
  end

  // one apb transfer: setup, access, then idle
  task automatic apb_transfer(input logic [APB_ADDR_W-1:0] addr, input logic wr,
                              input logic [APB_DATA_W-1:0] data);
    @(negedge clk_rtx);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk_rtx);
    penable = 1'b1;
    @(posedge clk_rtx); // access completes here
    rd_data = prdata;
    rd_err  = pslverr;
    assert (pready) else begin
      $display("[FAIL] %0t pready low in access phase at 0x%02h", $time, addr);
      errs++;
    end
    @(negedge clk_rtx);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // start one frame, clear enable right away so exactly one frame comes out
  task automatic render_frame(input logic [APB_DATA_W-1:0] ctrl_word);
    npix = 0;
    apb_transfer(ADDR_CTRL, 1'b1, ctrl_word);
    wait (npix > 0);
    apb_transfer(ADDR_CTRL, 1'b1, '0);
    wait (npix >= NPIX);
    repeat (4 * SCENE_DEPTH + 8) @(negedge clk_rtx); // a next frame would show by now
    assert (npix == NPIX) else begin
      $display("[FAIL] %0t frame gave %0d pixels, want %0d", $time, npix, NPIX);
      errs++;
    end
  endtask

  initial begin
    int pc;
    int seen;
    int writes;
    int cases;
    int bad_cases;
    int case_base;
    logic [31:0] a;
    logic [31:0] b;
    sys_rst = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    $readmemh("bench/scene_cases.txt", cmds);
    writes = 0;
    for (int i = 0; i < NWORDS; i += 3) begin
      case (cmds[i])
        1, 2, 3: writes += 1;
        5: writes += 2; // enable, then disable
        6: begin
          limit += writes * 2 + NPIX * 8 + 16;
          writes = 0;
        end
        default: ;
      endcase
    end
    limit = limit * 2;
    repeat (16) @(posedge clk_rtx);
    @(negedge clk_rtx);
    sys_rst = 1'b0;
    pc = 0;
    cases = 0;
    bad_cases = 0;
    case_base = 0;
    while (pc < NWORDS && cmds[pc] inside {[1:8]}) begin
      a = cmds[pc+1];
      b = cmds[pc+2];
      case (cmds[pc])
        1: apb_transfer(a[APB_ADDR_W-1:0], 1'b1, b);
        2: begin
          apb_transfer(a[APB_ADDR_W-1:0], 1'b0, '0);
          assert (rd_data == b && !rd_err) else begin
            $display("[FAIL] %0t read 0x%02h gave 0x%08h err %0b, want 0x%08h",
                     $time, a[7:0], rd_data, rd_err, b);
            errs++;
          end
        end
        3: begin
          apb_transfer(a[APB_ADDR_W-1:0], 1'b0, '0);
          assert (rd_err) else begin
            $display("[FAIL] %0t address 0x%02h gave no pslverr", $time, a[7:0]);
            errs++;
          end
        end
        4: assert (frame[int'(a[7:0]) * FRAME_H + int'(a[15:8])] == b[COLOR_W-1:0]) else begin
          $display("[FAIL] %0t pixel h=%0d v=%0d is 0x%04h, want 0x%04h", $time, a[15:8],
                   a[7:0], frame[int'(a[7:0]) * FRAME_H + int'(a[15:8])], b[COLOR_W-1:0]);
          errs++;
        end
        5: render_frame(b);
        6: begin
          cases++;
          if (errs != case_base)
            bad_cases++;
          $display("case %0d: %s, %0d errors", cases, (errs == case_base) ? "ok" : "bad",
                   errs - case_base);
          case_base = errs;
        end
        7: begin
          seen = npix;
          repeat (a) @(negedge clk_rtx);
          assert (npix == seen) else begin
            $display("ray_done pulsed %0d times while enable was clear", npix - seen);
            errs++;
          end
        end
        8: begin
          seen = 0;
          for (int k = 0; k < NPIX; k++)
            if (frame[k] == a[COLOR_W-1:0])
              seen++;
          assert (seen == b) else begin
            $display("[FAIL] %0t color 0x%04h on %0d pixels, want %0d", $time, a[15:0], seen, b);
            errs++;
          end
        end
        default: ;
      endcase
      pc += 3;
    end
    $display("%0d cases, %0d failed, %0d errors", cases, bad_cases, errs);
    if (errs == 0 && cases > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* bench/scene_cases.txt */
// op a b in hex: 1 write addr data, 2 read addr expect, 3 unmapped addr, 4 sample hhvv color
// 5 render ctrl, 6 end case, 7 idle cycles, 8 count color pixels, 0 end of list
// case 1: quiet after reset, readback, unmapped addresses
7 30 0
1 68 12345678  1 6c 8055aaaa  2 68 12345678  2 6c 8055aaaa
1 04 00001234  2 04 00001234
3 20 0  3 80 0
6 0 0
// case 2: one sphere, radius 3 at (8,6), 29 pixels inside
1 04 0000001f  1 40 08060300  1 44 0010f800
5 0 3
4 0806 f800  4 0b06 f800  4 0c06 001f  4 0a08 f800
4 0b08 001f  4 0803 f800  4 0802 001f
8 f800 1d  8 001f a3
6 0 0
// case 3: rect 0 under nearer sphere 1, rects 2 and 3 tie on depth
1 04 00000000  1 40 02020907  1 44 802007e0  1 48 09070200  1 4c 0010f800
1 50 0c080e0a  1 54 8030ffe0  1 58 0c080e0a  1 5c 8030f81f
5 0 9
4 0907 f800  4 0202 07e0  4 0905 f800  4 0303 07e0  4 0a07 f800
4 0d09 ffe0  4 0c08 ffe0  4 0f0b 0000
8 f81f 0  8 ffe0 9
6 0 0
// case 4: obj_count 1 leaves only the rectangle
5 0 3
4 0907 07e0  4 0a07 0000  4 0d09 0000
8 07e0 30
6 0 0
0 0 0

/* logic/hit_test.sv */
`timescale 1ns/1ns
`default_nettype none

module hit_test (
  input  wire                               clk_rtx,
  input  wire                               sys_rst,
  // from decode
  input  wire                               kind,
  input  wire [rtx_pkg::COORD_W-1:0]        dx,
  input  wire [rtx_pkg::COORD_W-1:0]        dy,
  input  wire [2*rtx_pkg::COORD_W-1:0]      r_sq,
  input  wire                               in_rect,
  input  wire [rtx_pkg::DEPTH_W-1:0]        depth_in,
  input  wire [rtx_pkg::COLOR_W-1:0]        color_in,
  input  wire rtx_pkg::ray_tag_t            tag,
  input  wire                               valid,
  // to result stage
  output logic                              hit,
  output logic [rtx_pkg::DEPTH_W-1:0]       depth,
  output logic [rtx_pkg::COLOR_W-1:0]       color,
  output rtx_pkg::ray_tag_t                 tag_q,
  output logic                              valid_q
);
  import rtx_pkg::*;

  logic [2*COORD_W-1:0] dx_sq;
  logic [2*COORD_W-1:0] dy_sq;
  logic [2*COORD_W:0]   dist_sq; // one extra bit for the carry
  logic                 sph_hit;

  assign dx_sq   = dx * dx;
  assign dy_sq   = dy * dy;
  assign dist_sq = dx_sq + dy_sq;
  assign sph_hit = (dist_sq <= {1'b0, r_sq}); // on the rim counts as a hit

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) valid_q <= 1'b0;
    else valid_q <= valid;
    hit   <= kind ? in_rect : sph_hit; // rect test already done in decode
    depth <= depth_in;
    color <= color_in;
    tag_q <= tag;
  end

endmodule
`default_nettype wire

/* logic/nearest_hit.sv */
`timescale 1ns/1ns
`default_nettype none

module nearest_hit (
  input  wire                           clk_rtx,
  input  wire                           sys_rst,
  input  wire                           hit,
  input  wire [rtx_pkg::DEPTH_W-1:0]    depth,
  input  wire [rtx_pkg::COLOR_W-1:0]    color,
  input  wire rtx_pkg::ray_tag_t        tag,
  input  wire                           valid,
  input  wire [rtx_pkg::COLOR_W-1:0]    bg_color,
  output rtx_pkg::pixel_t               pixel,
  output logic                          ray_done
);
  import rtx_pkg::*;

  logic               best_hit; // running winner for the current ray
  logic [DEPTH_W-1:0] best_depth;
  logic [COLOR_W-1:0] best_color;

  logic               base_hit;
  logic               take;
  logic               nxt_hit;
  logic [DEPTH_W-1:0] nxt_depth;
  logic [COLOR_W-1:0] nxt_color;

  // a first object starts from no hit
  assign base_hit = best_hit & ~tag.first;

  // only a strictly nearer hit wins so equal depth keeps the lower index
  assign take = hit && (!base_hit || (depth < best_depth));

  assign nxt_hit   = base_hit | take;
  assign nxt_depth = take ? depth : best_depth;
  assign nxt_color = take ? color : best_color;

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      best_hit <= 1'b0;
      ray_done <= 1'b0;
    end else begin
      ray_done <= valid & tag.last; // one pulse per ray
      if (valid) best_hit <= nxt_hit;
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (valid) begin
      best_depth <= nxt_depth;
      best_color <= nxt_color;
    end
    if (valid && tag.last) begin
      pixel.color <= nxt_hit ? nxt_color : bg_color;
      pixel.h     <= tag.h;
      pixel.v     <= tag.v;
    end
  end

endmodule
`default_nettype wire

/* logic/object_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module object_decode (
  input  wire                               clk_rtx,
  input  wire                               sys_rst,
  input  wire rtx_pkg::object_t             obj,
  input  wire rtx_pkg::ray_tag_t            tag,
  input  wire                               issue_valid,
  output logic                              kind,
  output logic [rtx_pkg::COORD_W-1:0]       dx,
  output logic [rtx_pkg::COORD_W-1:0]       dy,
  output logic [2*rtx_pkg::COORD_W-1:0]     r_sq,
  output logic                              in_rect,
  output logic [rtx_pkg::DEPTH_W-1:0]       depth,
  output logic [rtx_pkg::COLOR_W-1:0]       color,
  output rtx_pkg::ray_tag_t                 tag_q,
  output logic                              valid_q
);
  import rtx_pkg::*;

  sphere_t            sph;
  rect_t              rct;
  logic [COORD_W-1:0] dx_c;
  logic [COORD_W-1:0] dy_c;
  logic               in_rect_c;

  assign sph = obj.shape.sphere; // same word read two ways
  assign rct = obj.shape.rect;

  // absolute distance from the sphere center
  assign dx_c = (tag.h >= sph.cx) ? tag.h - sph.cx : sph.cx - tag.h;
  assign dy_c = (tag.v >= sph.cy) ? tag.v - sph.cy : sph.cy - tag.v;

  assign in_rect_c = (tag.h >= rct.x0) && (tag.h <= rct.x1) &&
                     (tag.v >= rct.y0) && (tag.v <= rct.y1); // inclusive

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) valid_q <= 1'b0;
    else valid_q <= issue_valid;
    kind    <= obj.kind;
    dx      <= dx_c;
    dy      <= dy_c;
    r_sq    <= sph.radius * sph.radius; // 16 bit product
    in_rect <= in_rect_c;
    depth   <= obj.depth;
    color   <= obj.color;
    tag_q   <= tag;
  end

endmodule
`default_nettype wire

/* logic/ray_scheduler.sv */
`timescale 1ns/1ns
`default_nettype none

module ray_scheduler (
  input  wire                           clk_rtx,
  input  wire                           sys_rst,
  input  wire rtx_pkg::ctrl_t           ctrl,
  output logic [rtx_pkg::OBJ_IDX_W-1:0] obj_idx,
  output rtx_pkg::ray_tag_t             tag,   // one cycle behind obj_idx
  output logic                          issue_valid
);
  import rtx_pkg::*;

  logic                 busy;
  logic [OBJ_CNT_W-1:0] cnt;  // objects per ray latched at frame start
  logic [OBJ_IDX_W-1:0] idx;
  logic [COORD_W-1:0]   h;
  logic [COORD_W-1:0]   v;
  logic                 first_obj;
  logic                 last_obj;
  logic                 last_h;
  logic                 last_v;
  logic                 frame_end;
  logic                 frame_go;
  logic [OBJ_CNT_W-1:0] start_cnt;

  assign first_obj = (idx == '0);
  assign last_obj  = ({1'b0, idx} == cnt - 1'b1);
  assign last_h    = (h == COORD_W'(FRAME_H - 1));
  assign last_v    = (v == COORD_W'(FRAME_V - 1));
  assign frame_end = busy & last_obj & last_h & last_v;

  // enable and count only matter at a frame boundary
  assign frame_go  = ctrl.enable && (ctrl.obj_count != '0);
  assign start_cnt = (ctrl.obj_count > OBJ_CNT_W'(SCENE_DEPTH)) ? OBJ_CNT_W'(SCENE_DEPTH)
                                                                : ctrl.obj_count;

  assign obj_idx = idx; // straight to the scene memory

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      busy <= 1'b0;
      cnt  <= '0;
      idx  <= '0;
      h    <= '0;
      v    <= '0;
    end else if (!busy || frame_end) begin
      busy <= frame_go; // back to back frames with no gap
      if (frame_go) cnt <= start_cnt;
      idx <= '0;
      h   <= '0;
      v   <= '0;
    end else if (last_obj) begin
      idx <= '0;
      if (last_h) begin
        h <= '0;
        v <= v + 1'b1;
      end else begin
        h <= h + 1'b1;
      end
    end else begin
      idx <= idx + 1'b1;
    end
  end

  // delay tag one cycle to keep step with the memory read
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) issue_valid <= 1'b0;
    else issue_valid <= busy;
    tag <= '{h: h, v: v, first: first_obj, last: last_obj};
  end

endmodule
`default_nettype wire

/* logic/rtx.sv */
`timescale 1ns/1ns
`default_nettype none

module rtx (
  input  wire                              clk_rtx,
  input  wire                              sys_rst,
  input  wire [rtx_pkg::APB_ADDR_W-1:0]    paddr,
  input  wire                              psel,
  input  wire                              penable,
  input  wire                              pwrite,
  input  wire [rtx_pkg::APB_DATA_W-1:0]    pwdata,
  output logic [rtx_pkg::APB_DATA_W-1:0]   prdata,
  output logic                             pready,
  output logic                             pslverr,
  output rtx_pkg::pixel_t                  pixel,
  output logic                             ray_done
);
  import rtx_pkg::*;

  object_t              obj;
  ctrl_t                ctrl;
  logic [COLOR_W-1:0]   bg_color;
  logic [OBJ_IDX_W-1:0] obj_idx;
  ray_tag_t             mem_tag;   // in step with obj
  logic                 mem_valid;

  // decode stage outputs
  logic                 dec_kind;
  logic [COORD_W-1:0]   dec_dx;
  logic [COORD_W-1:0]   dec_dy;
  logic [2*COORD_W-1:0] dec_r_sq;
  logic                 dec_in_rect;
  logic [DEPTH_W-1:0]   dec_depth;
  logic [COLOR_W-1:0]   dec_color;
  ray_tag_t             dec_tag;
  logic                 dec_valid;

  // execute stage outputs
  logic                 ex_hit;
  logic [DEPTH_W-1:0]   ex_depth;
  logic [COLOR_W-1:0]   ex_color;
  ray_tag_t             ex_tag;
  logic                 ex_valid;

  scene_buffer scene_buf (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .obj_idx(obj_idx), .obj(obj), .ctrl(ctrl), .bg_color(bg_color)
  );

  ray_scheduler sched (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst), .ctrl(ctrl),
    .obj_idx(obj_idx), .tag(mem_tag), .issue_valid(mem_valid)
  );

  object_decode decode (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst),
    .obj(obj), .tag(mem_tag), .issue_valid(mem_valid),
    .kind(dec_kind), .dx(dec_dx), .dy(dec_dy), .r_sq(dec_r_sq), .in_rect(dec_in_rect),
    .depth(dec_depth), .color(dec_color), .tag_q(dec_tag), .valid_q(dec_valid)
  );

  hit_test execute (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst),
    .kind(dec_kind), .dx(dec_dx), .dy(dec_dy), .r_sq(dec_r_sq), .in_rect(dec_in_rect),
    .depth_in(dec_depth), .color_in(dec_color), .tag(dec_tag), .valid(dec_valid),
    .hit(ex_hit), .depth(ex_depth), .color(ex_color), .tag_q(ex_tag), .valid_q(ex_valid)
  );

  nearest_hit result (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst),
    .hit(ex_hit), .depth(ex_depth), .color(ex_color), .tag(ex_tag), .valid(ex_valid),
    .bg_color(bg_color), .pixel(pixel), .ray_done(ray_done)
  );

endmodule
`default_nettype wire

/* logic/rtx_pkg.sv */
package rtx_pkg;

  // frame geometry
  localparam int FRAME_H = 16; // pixels per line
  localparam int FRAME_V = 12; // lines per frame
  localparam int COORD_W = 8;

  // scene storage
  localparam int SCENE_DEPTH = 8; // object slots
  localparam int OBJ_IDX_W   = 3;
  localparam int OBJ_CNT_W   = 4; // holds 0..8
  localparam int DEPTH_W     = 8; // smaller is nearer
  localparam int COLOR_W     = 16; // rgb565

  // apb address map, byte addresses
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL     = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_BG       = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_OBJ_BASE = 8'h40; // slot i at base + 8i

  typedef struct packed {
    logic [COORD_W-1:0] cx;
    logic [COORD_W-1:0] cy;
    logic [COORD_W-1:0] radius;
    logic [7:0]         pad;
  } sphere_t;

  typedef struct packed {
    logic [COORD_W-1:0] x0; // bounds are inclusive
    logic [COORD_W-1:0] y0;
    logic [COORD_W-1:0] x1;
    logic [COORD_W-1:0] y1;
  } rect_t;

  // same 32 bit shape word, read per object kind
  typedef union packed {
    sphere_t sphere;
    rect_t   rect;
  } shape_u;

  typedef struct packed {
    logic               kind;  // 0 sphere, 1 rectangle
    logic [6:0]         pad;
    logic [DEPTH_W-1:0] depth;
    logic [COLOR_W-1:0] color;
    shape_u             shape; // low apb word
  } object_t;

  typedef struct packed {
    logic [COORD_W-1:0] h;
    logic [COORD_W-1:0] v;
    logic               first; // first object of this ray
    logic               last;  // last object of this ray
  } ray_tag_t;

  typedef struct packed {
    logic [COLOR_W-1:0] color;
    logic [COORD_W-1:0] h;
    logic [COORD_W-1:0] v;
  } pixel_t;

  typedef struct packed {
    logic [OBJ_CNT_W-1:0] obj_count; // 0 keeps the engine idle
    logic                 enable;
  } ctrl_t;

endpackage

/* logic/scene_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module scene_buffer (
  input  wire                                 clk_rtx,
  input  wire                                 sys_rst,
  // apb slave
  input  wire [rtx_pkg::APB_ADDR_W-1:0]       paddr,
  input  wire                                 psel,
  input  wire                                 penable,
  input  wire                                 pwrite,
  input  wire [rtx_pkg::APB_DATA_W-1:0]       pwdata,
  output logic [rtx_pkg::APB_DATA_W-1:0]      prdata,
  output logic                                pready,
  output logic                                pslverr,
  // pipeline side
  input  wire [rtx_pkg::OBJ_IDX_W-1:0]        obj_idx,
  output rtx_pkg::object_t                    obj,
  output rtx_pkg::ctrl_t                      ctrl,
  output logic [rtx_pkg::COLOR_W-1:0]         bg_color
);
  import rtx_pkg::*;

  object_t obj_mem [SCENE_DEPTH]; // 64 bit slots, written per half

  logic                  access; // apb access phase
  logic                  hit_ctrl;
  logic                  hit_bg;
  logic                  hit_obj;
  logic                  addr_ok;
  logic [APB_ADDR_W-1:0] obj_off;
  logic [OBJ_IDX_W-1:0]  slot;
  logic                  hi_half; // word 1 holds kind, depth, color
  logic                  wr_en;

  assign access  = psel & penable;
  assign obj_off = paddr - ADDR_OBJ_BASE;
  assign slot    = obj_off[OBJ_IDX_W+2:3];
  assign hi_half = obj_off[2];

  // address decode, words only
  assign hit_ctrl = (paddr == ADDR_CTRL);
  assign hit_bg   = (paddr == ADDR_BG);
  assign hit_obj  = (paddr >= ADDR_OBJ_BASE) && (paddr < ADDR_OBJ_BASE + 8 * SCENE_DEPTH) &&
                    (paddr[1:0] == 2'b00);
  assign addr_ok  = hit_ctrl | hit_bg | hit_obj;

  assign pready  = access; // zero wait states
  assign pslverr = access & ~addr_ok; // unmapped, nothing changes
  assign wr_en   = access & pwrite & addr_ok;

  // control and background registers
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      ctrl     <= '0;
      bg_color <= '0;
    end else if (wr_en) begin
      if (hit_ctrl) ctrl <= ctrl_t'(pwdata[$bits(ctrl_t)-1:0]);
      if (hit_bg) bg_color <= pwdata[COLOR_W-1:0];
    end
  end

  // object memory, one half per apb write
  always_ff @(posedge clk_rtx) begin
    if (wr_en && hit_obj) begin
      if (hi_half) obj_mem[slot][2*APB_DATA_W-1:APB_DATA_W] <= pwdata;
      else obj_mem[slot][APB_DATA_W-1:0] <= pwdata;
    end
  end

  // registered read port for the pipeline
  always_ff @(posedge clk_rtx) begin
    obj <= obj_mem[obj_idx]; // lines up with the delayed ray tag
  end

  // apb read mux
  always_comb begin
    prdata = '0;
    if (hit_ctrl) begin
      prdata = APB_DATA_W'(ctrl);
    end else if (hit_bg) begin
      prdata = APB_DATA_W'(bg_color);
    end else if (hit_obj) begin
      if (hi_half) prdata = obj_mem[slot][2*APB_DATA_W-1:APB_DATA_W];
      else prdata = obj_mem[slot][APB_DATA_W-1:0];
    end
  end

endmodule
`default_nettype wire

/* src.f */
logic/rtx_pkg.sv
logic/scene_buffer.sv
logic/ray_scheduler.sv
logic/object_decode.sv
logic/hit_test.sv
logic/nearest_hit.sv
logic/rtx.sv
bench/rtx_tb.sv
